//--- hdl/mips_id_pkg.sv
/*
 * Shared definitions for the MIPS instruction decode stage:
 * widths, opcode and funct codes, ALU operation and result class codes,
 * field layouts of the instruction word and their union
 */
package mips_id_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int WORD_W     = 32;

    ////////////////////////////////////////
    // Primary opcode field, bits 31..26
    ////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J     = 6'h02, OP_JAL   = 6'h03, OP_BEQ   = 6'h04,
        OP_BNE     = 6'h05, OP_BGTZ  = 6'h07, OP_ADDI  = 6'h08, OP_ADDIU = 6'h09,
        OP_SLTI    = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI  = 6'h0c, OP_ORI   = 6'h0d,
        OP_XORI    = 6'h0e, OP_LUI   = 6'h0f, OP_LB    = 6'h20, OP_LH    = 6'h21,
        OP_LW      = 6'h23, OP_LBU   = 6'h24, OP_LHU   = 6'h25, OP_SB    = 6'h28,
        OP_SH      = 6'h29, OP_SW    = 6'h2b
    } opcode_e;

    // Funct field of SPECIAL, bits 5..0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    ////////////////////////////////////////
    // Operation code handed to execute
    ////////////////////////////////////////
    typedef enum logic [7:0] {
        ALU_NOP   = 8'h00, ALU_SRL   = 8'h02, ALU_SRA   = 8'h03, ALU_SLLV  = 8'h04,
        ALU_SRLV  = 8'h06, ALU_SRAV  = 8'h07, ALU_JR    = 8'h08, ALU_JALR  = 8'h09,
        ALU_ADD   = 8'h20, ALU_ADDU  = 8'h21, ALU_SUB   = 8'h22, ALU_SUBU  = 8'h23,
        ALU_AND   = 8'h24, ALU_OR    = 8'h25, ALU_XOR   = 8'h26, ALU_NOR   = 8'h27,
        ALU_SLT   = 8'h2a, ALU_SLTU  = 8'h2b, ALU_J     = 8'h4f, ALU_JAL   = 8'h50,
        ALU_BEQ   = 8'h51, ALU_BNE   = 8'h52, ALU_BGTZ  = 8'h54, ALU_ADDI  = 8'h55,
        ALU_ADDIU = 8'h56, ALU_SLTI  = 8'h57, ALU_SLTIU = 8'h58, ALU_ANDI  = 8'h59,
        ALU_ORI   = 8'h5a, ALU_XORI  = 8'h5b, ALU_LUI   = 8'h5c, ALU_SLL   = 8'h7c,
        ALU_LB    = 8'he0, ALU_LH    = 8'he1, ALU_LW    = 8'he3, ALU_LBU   = 8'he4,
        ALU_LHU   = 8'he5, ALU_SB    = 8'he8, ALU_SH    = 8'he9, ALU_SW    = 8'heb
    } alu_op_e;

    // Result class, picks the execute result mux input
    typedef enum logic [2:0] {
        SEL_NOP        = 3'b000,
        SEL_LOGIC      = 3'b001,
        SEL_SHIFT      = 3'b010,
        SEL_ARITH      = 3'b100,
        SEL_LOAD_STORE = 3'b111
    } alu_sel_e;

    ////////////////////////////////////////
    // Instruction field layouts
    ////////////////////////////////////////
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // Same word seen as R, I or J depending on opcode
    typedef union packed {
        logic [WORD_W-1:0] raw;
        r_fmt_t            r;
        i_fmt_t            i;
        j_fmt_t            j;
    } inst_word_u;

endpackage

//--- hdl/id_ctrl_if.sv
/*
 * Decoded control bundle of the decode stage:
 * ALU code and class, datapath selects, memory enables, immediate
 */
`timescale 1ns/1ps

interface id_ctrl_if;

    mips_id_pkg::alu_op_e             alu_op;
    mips_id_pkg::alu_sel_e            alu_sel;
    logic                             alu_src;      // Operand B from immediate
    logic                             reg_dst;      // Write to rd, else rt
    logic                             reg_write;
    logic                             mem_read;
    logic                             mem_write;
    logic [mips_id_pkg::WORD_W-1:0]   extended_imm;

    // Driven by the decoder only
    modport producer (
        output alu_op, alu_sel, alu_src, reg_dst, reg_write,
        output mem_read, mem_write, extended_imm
    );

    modport consumer (
        input alu_op, alu_sel, alu_src, reg_dst, reg_write,
        input mem_read, mem_write, extended_imm
    );

endinterface

//--- hdl/id_pipe_reg.sv
/*
 * IF/ID stage register: instruction word, PC and valid,
 * with hold on stall and bubble insertion
 */
`timescale 1ns/1ps

module id_pipe_reg (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           stall,
    input  logic                           if_valid,
    input  logic [mips_id_pkg::WORD_W-1:0] instruction,
    input  logic [mips_id_pkg::WORD_W-1:0] pc,
    output mips_id_pkg::inst_word_u        inst,
    output logic [mips_id_pkg::WORD_W-1:0] inst_pc,
    output logic                           id_valid
);

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst     <= '0;    // Decodes as SLL r0, harmless
            inst_pc  <= '0;
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= if_valid;    // Bubble when fetch has nothing
            if (if_valid) begin
                inst.raw <= instruction;
                inst_pc  <= pc;
            end
        end
    end

    // Held state must not move while execute pushes back
    hold_on_stall: assert property (
        @(posedge clk) disable iff (!rstn)
        stall |=> $stable(inst) && $stable(inst_pc) && $stable(id_valid)
    ) else $error("decode stage register changed under stall");

endmodule

//--- hdl/ctrl_decoder.sv
/*
 * Control decoder: operation code, result class, datapath and
 * memory controls and the extended immediate from the held word
 */
`timescale 1ns/1ps

module ctrl_decoder (
    input  mips_id_pkg::inst_word_u inst,
    id_ctrl_if.producer             ctrl
);

    mips_id_pkg::alu_op_e  op;
    mips_id_pkg::alu_sel_e sel;
    logic                  is_special;
    logic                  is_load;
    logic                  is_store;
    logic                  shamt_imm;
    logic                  zero_ext;

    assign is_special = (inst.r.opcode == mips_id_pkg::OP_SPECIAL);

    ////////////////////////////////////////
    // Operation code
    ////////////////////////////////////////
    always_comb begin
        op = mips_id_pkg::ALU_NOP;
        if (is_special) begin
            case (inst.r.funct)
                mips_id_pkg::FN_ADD:  op = mips_id_pkg::ALU_ADD;
                mips_id_pkg::FN_ADDU: op = mips_id_pkg::ALU_ADDU;
                mips_id_pkg::FN_SUB:  op = mips_id_pkg::ALU_SUB;
                mips_id_pkg::FN_SUBU: op = mips_id_pkg::ALU_SUBU;
                mips_id_pkg::FN_SLT:  op = mips_id_pkg::ALU_SLT;
                mips_id_pkg::FN_SLTU: op = mips_id_pkg::ALU_SLTU;
                mips_id_pkg::FN_AND:  op = mips_id_pkg::ALU_AND;
                mips_id_pkg::FN_OR:   op = mips_id_pkg::ALU_OR;
                mips_id_pkg::FN_XOR:  op = mips_id_pkg::ALU_XOR;
                mips_id_pkg::FN_NOR:  op = mips_id_pkg::ALU_NOR;
                mips_id_pkg::FN_SLL:  op = mips_id_pkg::ALU_SLL;
                mips_id_pkg::FN_SRL:  op = mips_id_pkg::ALU_SRL;
                mips_id_pkg::FN_SRA:  op = mips_id_pkg::ALU_SRA;
                mips_id_pkg::FN_SLLV: op = mips_id_pkg::ALU_SLLV;
                mips_id_pkg::FN_SRLV: op = mips_id_pkg::ALU_SRLV;
                mips_id_pkg::FN_SRAV: op = mips_id_pkg::ALU_SRAV;
                mips_id_pkg::FN_JR:   op = mips_id_pkg::ALU_JR;
                mips_id_pkg::FN_JALR: op = mips_id_pkg::ALU_JALR;
                default:              op = mips_id_pkg::ALU_NOP;
            endcase
        end else begin
            case (inst.i.opcode)
                mips_id_pkg::OP_ADDI:  op = mips_id_pkg::ALU_ADDI;
                mips_id_pkg::OP_ADDIU: op = mips_id_pkg::ALU_ADDIU;
                mips_id_pkg::OP_SLTI:  op = mips_id_pkg::ALU_SLTI;
                mips_id_pkg::OP_SLTIU: op = mips_id_pkg::ALU_SLTIU;
                mips_id_pkg::OP_ANDI:  op = mips_id_pkg::ALU_ANDI;
                mips_id_pkg::OP_ORI:   op = mips_id_pkg::ALU_ORI;
                mips_id_pkg::OP_XORI:  op = mips_id_pkg::ALU_XORI;
                mips_id_pkg::OP_LUI:   op = mips_id_pkg::ALU_LUI;
                mips_id_pkg::OP_LB:    op = mips_id_pkg::ALU_LB;
                mips_id_pkg::OP_LBU:   op = mips_id_pkg::ALU_LBU;
                mips_id_pkg::OP_LH:    op = mips_id_pkg::ALU_LH;
                mips_id_pkg::OP_LHU:   op = mips_id_pkg::ALU_LHU;
                mips_id_pkg::OP_LW:    op = mips_id_pkg::ALU_LW;
                mips_id_pkg::OP_SB:    op = mips_id_pkg::ALU_SB;
                mips_id_pkg::OP_SH:    op = mips_id_pkg::ALU_SH;
                mips_id_pkg::OP_SW:    op = mips_id_pkg::ALU_SW;
                mips_id_pkg::OP_J:     op = mips_id_pkg::ALU_J;
                mips_id_pkg::OP_JAL:   op = mips_id_pkg::ALU_JAL;
                mips_id_pkg::OP_BEQ:   op = mips_id_pkg::ALU_BEQ;
                mips_id_pkg::OP_BNE:   op = mips_id_pkg::ALU_BNE;
                mips_id_pkg::OP_BGTZ:  op = mips_id_pkg::ALU_BGTZ;
                default:               op = mips_id_pkg::ALU_NOP;
            endcase
        end
    end

    // Result class follows from the operation; jumps stay SEL_NOP
    always_comb begin
        case (op)
            mips_id_pkg::ALU_ADD, mips_id_pkg::ALU_ADDU, mips_id_pkg::ALU_SUB,
            mips_id_pkg::ALU_SUBU, mips_id_pkg::ALU_SLT, mips_id_pkg::ALU_SLTU,
            mips_id_pkg::ALU_ADDI, mips_id_pkg::ALU_ADDIU, mips_id_pkg::ALU_SLTI,
            mips_id_pkg::ALU_SLTIU:
                sel = mips_id_pkg::SEL_ARITH;
            mips_id_pkg::ALU_AND, mips_id_pkg::ALU_OR, mips_id_pkg::ALU_XOR,
            mips_id_pkg::ALU_NOR, mips_id_pkg::ALU_ANDI, mips_id_pkg::ALU_ORI,
            mips_id_pkg::ALU_XORI, mips_id_pkg::ALU_LUI:
                sel = mips_id_pkg::SEL_LOGIC;
            mips_id_pkg::ALU_SLL, mips_id_pkg::ALU_SRL, mips_id_pkg::ALU_SRA,
            mips_id_pkg::ALU_SLLV, mips_id_pkg::ALU_SRLV, mips_id_pkg::ALU_SRAV:
                sel = mips_id_pkg::SEL_SHIFT;
            mips_id_pkg::ALU_LB, mips_id_pkg::ALU_LBU, mips_id_pkg::ALU_LH,
            mips_id_pkg::ALU_LHU, mips_id_pkg::ALU_LW, mips_id_pkg::ALU_SB,
            mips_id_pkg::ALU_SH, mips_id_pkg::ALU_SW:
                sel = mips_id_pkg::SEL_LOAD_STORE;
            default:
                sel = mips_id_pkg::SEL_NOP;
        endcase
    end

    assign is_load   = op inside {mips_id_pkg::ALU_LB, mips_id_pkg::ALU_LBU,
                                  mips_id_pkg::ALU_LH, mips_id_pkg::ALU_LHU,
                                  mips_id_pkg::ALU_LW};
    assign is_store  = op inside {mips_id_pkg::ALU_SB, mips_id_pkg::ALU_SH,
                                  mips_id_pkg::ALU_SW};
    assign shamt_imm = op inside {mips_id_pkg::ALU_SLL, mips_id_pkg::ALU_SRL,
                                  mips_id_pkg::ALU_SRA};    // Only reachable via funct
    assign zero_ext  = op inside {mips_id_pkg::ALU_ANDI, mips_id_pkg::ALU_ORI,
                                  mips_id_pkg::ALU_XORI, mips_id_pkg::ALU_LUI};

    ////////////////////////////////////////
    // Control outputs
    ////////////////////////////////////////
    assign ctrl.alu_op    = op;
    assign ctrl.alu_sel   = sel;
    assign ctrl.alu_src   = (!is_special && sel != mips_id_pkg::SEL_NOP) || shamt_imm;
    assign ctrl.reg_dst   = is_special;
    assign ctrl.reg_write = sel inside {mips_id_pkg::SEL_ARITH, mips_id_pkg::SEL_LOGIC,
                                        mips_id_pkg::SEL_SHIFT}
                            || is_load
                            || op inside {mips_id_pkg::ALU_JALR, mips_id_pkg::ALU_JAL};
    assign ctrl.mem_read  = is_load;
    assign ctrl.mem_write = is_store;

    // Shift amount, logical immediates, then sign extension for the rest
    assign ctrl.extended_imm =
        shamt_imm ? {{(mips_id_pkg::WORD_W-mips_id_pkg::REG_ADDR_W){1'b0}}, inst.r.shamt} :
        zero_ext  ? {16'b0, inst.i.imm} :
                    {{16{inst.i.imm[15]}}, inst.i.imm};

endmodule

//--- hdl/branch_resolver.sv
/*
 * Jump and branch resolution in decode:
 * taken decision from register data, target from PC+4
 */
`timescale 1ns/1ps

module branch_resolver (
    input  mips_id_pkg::inst_word_u        inst,
    input  logic [mips_id_pkg::WORD_W-1:0] inst_pc,
    input  logic                           id_valid,
    input  logic [mips_id_pkg::WORD_W-1:0] rs_data,
    input  logic [mips_id_pkg::WORD_W-1:0] rt_data,
    id_ctrl_if.consumer                    ctrl,
    output logic [mips_id_pkg::WORD_W-1:0] jump_pc,
    output logic                           do_jump
);

    logic [mips_id_pkg::WORD_W-1:0] pc_plus_4;
    logic [mips_id_pkg::WORD_W-1:0] branch_pc;
    logic                           take;

    assign pc_plus_4 = inst_pc + 32'd4;
    assign branch_pc = pc_plus_4 + {ctrl.extended_imm[29:0], 2'b00};    // Word offset

    ////////////////////////////////////////
    // Decision and target
    ////////////////////////////////////////
    always_comb begin
        take    = 1'b0;
        jump_pc = '0;
        case (inst.r.opcode)
            mips_id_pkg::OP_SPECIAL: begin
                if (inst.r.funct == mips_id_pkg::FN_JR ||
                    inst.r.funct == mips_id_pkg::FN_JALR) begin
                    take    = 1'b1;
                    jump_pc = rs_data;
                end
            end
            mips_id_pkg::OP_J, mips_id_pkg::OP_JAL: begin
                take    = 1'b1;
                jump_pc = {pc_plus_4[31:28], inst.j.target, 2'b00};    // Same 256 MB region
            end
            mips_id_pkg::OP_BEQ: begin
                take    = (rs_data == rt_data);
                jump_pc = branch_pc;
            end
            mips_id_pkg::OP_BNE: begin
                take    = (rs_data != rt_data);
                jump_pc = branch_pc;
            end
            mips_id_pkg::OP_BGTZ: begin
                take    = !rs_data[31] && (|rs_data);    // Signed greater than zero
                jump_pc = branch_pc;
            end
            default: begin
                take    = 1'b0;
                jump_pc = '0;
            end
        endcase
    end

    assign do_jump = take && id_valid;    // No redirect from a bubble

endmodule

//--- hdl/id_stage.sv
/*
 * Decode stage top: stage register, control decoder and branch
 * resolver, fanned out to plain ports
 */
`timescale 1ns/1ps

module id_stage (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               stall,
    input  logic                               if_valid,
    input  logic [mips_id_pkg::WORD_W-1:0]     instruction,
    input  logic [mips_id_pkg::WORD_W-1:0]     pc,
    input  logic [mips_id_pkg::WORD_W-1:0]     rs_data,
    input  logic [mips_id_pkg::WORD_W-1:0]     rt_data,
    output logic [mips_id_pkg::REG_ADDR_W-1:0] rs,
    output logic [mips_id_pkg::REG_ADDR_W-1:0] rt,
    output logic [mips_id_pkg::REG_ADDR_W-1:0] rd,
    output logic [mips_id_pkg::WORD_W-1:0]     inst_out,
    output logic [mips_id_pkg::WORD_W-1:0]     pc_out,
    output logic                               id_valid,
    output mips_id_pkg::alu_op_e               alu_op,
    output mips_id_pkg::alu_sel_e              alu_sel,
    output logic                               alu_src,
    output logic                               reg_dst,
    output logic                               reg_write,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [mips_id_pkg::WORD_W-1:0]     extended_imm,
    output logic [mips_id_pkg::WORD_W-1:0]     jump_pc,
    output logic                               do_jump
);

    mips_id_pkg::inst_word_u        inst;
    logic [mips_id_pkg::WORD_W-1:0] inst_pc;

    id_ctrl_if ctrl_bus ();

    id_pipe_reg i_id_pipe_reg (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .if_valid    (if_valid),
        .instruction (instruction),
        .pc          (pc),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .id_valid    (id_valid)
    );

    ctrl_decoder i_ctrl_decoder (
        .inst (inst),
        .ctrl (ctrl_bus.producer)
    );

    branch_resolver i_branch_resolver (
        .inst     (inst),
        .inst_pc  (inst_pc),
        .id_valid (id_valid),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .ctrl     (ctrl_bus.consumer),
        .jump_pc  (jump_pc),
        .do_jump  (do_jump)
    );

    // Register file addresses straight from the held word
    assign rs       = inst.r.rs;
    assign rt       = inst.r.rt;
    assign rd       = inst.r.rd;
    assign inst_out = inst.raw;
    assign pc_out   = inst_pc;

    assign alu_op       = ctrl_bus.alu_op;
    assign alu_sel      = ctrl_bus.alu_sel;
    assign alu_src      = ctrl_bus.alu_src;
    assign reg_dst      = ctrl_bus.reg_dst;
    assign reg_write    = ctrl_bus.reg_write;
    assign mem_read     = ctrl_bus.mem_read;
    assign mem_write    = ctrl_bus.mem_write;
    assign extended_imm = ctrl_bus.extended_imm;

endmodule

//--- verif/tb_id_stage.sv
/*
 * Testbench for the decode stage: reads stimulus and expected values
 * from the vector file, drives the DUT, checks it, runs a watchdog
 */
`timescale 1ns/1ps

module tb_id_stage;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 3;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    SAMPLE_DELAY = 7;    // Just before the next rising edge
    localparam int    NUM_FIELDS   = 17;
    localparam string VECTOR_FILE  = "verif/id_vectors.txt";

    // One line of the vector file
    typedef struct packed {
        logic [31:0] if_valid;
        logic [31:0] stall;
        logic [31:0] instruction;
        logic [31:0] pc;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] id_valid;
        logic [31:0] alu_op;
        logic [31:0] alu_sel;
        logic [31:0] alu_src;
        logic [31:0] reg_dst;
        logic [31:0] reg_write;
        logic [31:0] mem_read;
        logic [31:0] mem_write;
        logic [31:0] extended_imm;
        logic [31:0] do_jump;
        logic [31:0] jump_pc;
    } vector_t;

    logic        clk;
    logic        rstn;
    logic        stall;
    logic        if_valid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] inst_out;
    logic [31:0] pc_out;
    logic        id_valid;
    logic [7:0]  alu_op;
    logic [2:0]  alu_sel;
    logic        alu_src;
    logic        reg_dst;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] extended_imm;
    logic [31:0] jump_pc;
    logic        do_jump;

    vector_t     vectors[$];
    logic        vectors_ready;
    int          watchdog_ns;
    logic [31:0] exp_inst;    // Word the stage should hold
    logic [31:0] exp_pc;

    id_stage i_id_stage (
        .clk          (clk),
        .rstn         (rstn),
        .stall        (stall),
        .if_valid     (if_valid),
        .instruction  (instruction),
        .pc           (pc),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .rs           (rs),
        .rt           (rt),
        .rd           (rd),
        .inst_out     (inst_out),
        .pc_out       (pc_out),
        .id_valid     (id_valid),
        .alu_op       (alu_op),
        .alu_sel      (alu_sel),
        .alu_src      (alu_src),
        .reg_dst      (reg_dst),
        .reg_write    (reg_write),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .extended_imm (extended_imm),
        .jump_pc      (jump_pc),
        .do_jump      (do_jump)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Checks and helpers
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Testbench failed");
            $fatal(1, "check of %s did not match", name);
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      rc;
        int      cnt;
        int      line_no;
        string   line;
        vector_t v;
        line_no = 0;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VECTOR_FILE);
            $display("Testbench failed");
            $fatal(1, "vector file missing");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc == 0) begin
                    break;    // Nothing left to read
                end
                line_no++;
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v.if_valid, v.stall, v.instruction, v.pc, v.rs_data,
                              v.rt_data, v.id_valid, v.alu_op, v.alu_sel, v.alu_src,
                              v.reg_dst, v.reg_write, v.mem_read, v.mem_write,
                              v.extended_imm, v.do_jump, v.jump_pc);
                if (cnt == NUM_FIELDS) begin
                    vectors.push_back(v);
                end else if (cnt > 0) begin    // Comment and blank lines give 0
                    $display("vector file line %0d holds %0d of %0d fields",
                             line_no, cnt, NUM_FIELDS);
                    $display("Testbench failed");
                    $fatal(1, "short vector line");
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("the vector file %s holds no vectors", VECTOR_FILE);
                $display("Testbench failed");
                $fatal(1, "empty vector file");
            end
        end
    endtask

    task automatic drive_fetch(input vector_t v);
        if_valid    = v.if_valid[0];
        stall       = v.stall[0];
        instruction = v.instruction;
        pc          = v.pc;
    endtask

    task automatic check_reset_state();
        check_value("id_valid", 32'(id_valid), 32'd0);
        check_value("do_jump", 32'(do_jump), 32'd0);
        check_value("mem_read", 32'(mem_read), 32'd0);
        check_value("mem_write", 32'(mem_write), 32'd0);
    endtask

    task automatic check_outputs(input vector_t v);
        check_value("id_valid", 32'(id_valid), v.id_valid);
        check_value("do_jump", 32'(do_jump), v.do_jump);
        check_value("inst_out", inst_out, exp_inst);
        check_value("pc_out", pc_out, exp_pc);
        check_value("rs", 32'(rs), 32'(exp_inst[25:21]));
        check_value("rt", 32'(rt), 32'(exp_inst[20:16]));
        check_value("rd", 32'(rd), 32'(exp_inst[15:11]));
        if (v.id_valid[0]) begin    // Controls of a bubble are don't care
            check_value("alu_op", 32'(alu_op), v.alu_op);
            check_value("alu_sel", 32'(alu_sel), v.alu_sel);
            check_value("alu_src", 32'(alu_src), v.alu_src);
            check_value("reg_dst", 32'(reg_dst), v.reg_dst);
            check_value("reg_write", 32'(reg_write), v.reg_write);
            check_value("mem_read", 32'(mem_read), v.mem_read);
            check_value("mem_write", 32'(mem_write), v.mem_write);
            check_value("extended_imm", extended_imm, v.extended_imm);
            check_value("jump_pc", jump_pc, v.jump_pc);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        rstn          = 1'b0;
        stall         = 1'b0;
        if_valid      = 1'b0;
        instruction   = '0;
        pc            = '0;
        rs_data       = '0;
        rt_data       = '0;
        exp_inst      = '0;    // Reset value of the held word
        exp_pc        = '0;
        vectors_ready = 1'b0;
        watchdog_ns   = 0;

        load_vectors();
        watchdog_ns   = (vectors.size() + 10) * CLK_PERIOD;
        vectors_ready = 1'b1;

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_reset_state();
        end
        rstn = 1'b1;
        drive_fetch(vectors[0]);
        #(SAMPLE_DELAY - DRIVE_DELAY);
        check_reset_state();    // Nothing accepted yet

        // Register data belongs to the word held after the edge
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            rs_data = vectors[i].rs_data;
            rt_data = vectors[i].rt_data;
            if (i + 1 < vectors.size()) begin
                drive_fetch(vectors[i + 1]);
            end else begin
                if_valid = 1'b0;
                stall    = 1'b0;
            end
            if (vectors[i].if_valid[0] && !vectors[i].stall[0]) begin
                exp_inst = vectors[i].instruction;
                exp_pc   = vectors[i].pc;
            end
            #(SAMPLE_DELAY - DRIVE_DELAY);
            check_outputs(vectors[i]);
        end

        $display("Testbench passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (vectors_ready);
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- compile.f
hdl/mips_id_pkg.sv
hdl/id_ctrl_if.sv
hdl/id_pipe_reg.sv
hdl/ctrl_decoder.sv
hdl/branch_resolver.sv
hdl/id_stage.sv
verif/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it into sim.log
# and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_id_stage -o sim_tb_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- verif/id_vectors.txt
# stimulus: if_valid stall instruction pc rs_data rt_data
# expected: id_valid alu_op alu_sel alu_src reg_dst reg_write mem_read mem_write ext_imm do_jump jump_pc
1 0 00221820 00400000 00000005 00000007  1 20 4 0 1 1 0 0 00001820 0 00000000
1 0 00a62023 00400004 00000000 00000000  1 23 4 0 1 1 0 0 00002023 0 00000000
1 0 01093827 00400008 00000000 00000000  1 27 1 0 1 1 0 0 00003827 0 00000000
1 0 00031140 0040000c 00000000 00000000  1 7c 2 1 1 1 0 0 00000005 0 00000000
1 0 018b5007 00400010 00000000 00000000  1 07 2 0 1 1 0 0 00005007 0 00000000
1 0 31288001 00400014 00000000 00000000  1 59 1 1 0 1 0 0 00008001 0 00000000
1 0 21288001 00400018 00000000 00000000  1 55 4 1 0 1 0 0 ffff8001 0 00000000
1 0 2c830010 0040001c 00000000 00000000  1 58 4 1 0 1 0 0 00000010 0 00000000
1 0 3c05abcd 00400020 00000000 00000000  1 5c 1 1 0 1 0 0 0000abcd 0 00000000
1 0 8fa6fff8 00400024 00000000 00000000  1 e3 7 1 0 1 1 0 fffffff8 0 00000000
1 0 a0870003 00400028 00000000 00000000  1 e8 7 1 0 0 0 1 00000003 0 00000000
1 0 08100040 8ffffffc 00000000 00000000  1 4f 0 0 0 0 0 0 00000040 1 90400100
1 0 0c000123 00400040 00000000 00000000  1 50 0 0 0 1 0 0 00000123 1 0000048c
1 0 03e00008 00400048 00401234 00000000  1 08 0 0 1 0 0 0 00000008 1 00401234
1 0 10220004 00400050 00001234 00001234  1 51 0 0 0 0 0 0 00000004 1 00400064
1 0 10220004 00400058 00000001 00000002  1 51 0 0 0 0 0 0 00000004 0 0040006c
1 0 1464fffe 00400060 00000001 00000002  1 52 0 0 0 0 0 0 fffffffe 1 0040005c
1 0 1464fffe 00400068 00000055 00000055  1 52 0 0 0 0 0 0 fffffffe 0 00400064
1 0 1ca00008 00400070 fffffff0 00000000  1 54 0 0 0 0 0 0 00000008 0 00400094
1 1 00221820 00400078 00000001 00000000  1 54 0 0 0 0 0 0 00000008 1 00400094
0 0 00221820 0040007c 00000001 00000000  0 54 0 0 0 0 0 0 00000008 0 00400094
1 0 0120f809 00400080 00400200 00000000  1 09 0 0 1 1 0 0 fffff809 1 00400200
